//--- common/arcade_pkg.sv
// Shared constants for the arcade board glue.
// Widths, download indices, game codes, menu defaults and status bit
// positions. Every file refers to these by scoped name.

package arcade_pkg;

	// ======================================================================
	// Widths
	// ======================================================================

	// Host status word
	localparam int STATUS_W = 32;
	// Download address and data byte
	localparam int ADDR_W   = 25;
	localparam int BYTE_W   = 8;
	// USB joystick word, also the parallel DB15 word
	localparam int JOY_W    = 16;
	// Active-low player word seen by the core
	localparam int PLAYER_W = 16;
	// One trackball axis
	localparam int TRACK_W  = 7;
	// One signed audio sample
	localparam int SAMPLE_W = 16;
	// OSD menu mask
	localparam int MENU_W   = 16;

	// ======================================================================
	// DIP switches
	// ======================================================================

	// Eight DIP bytes in the DIP download
	localparam int NUM_DIP   = 8;
	// Address bits that pick a DIP slot
	localparam int DIP_SEL_W = $clog2(NUM_DIP);

	// ======================================================================
	// Download indices and game codes
	// ======================================================================

	// ROM image
	localparam int IDX_ROM  = 0;
	// Game-select byte for the multigame core
	localparam int IDX_GAME = 1;
	// DIP switch bytes
	localparam int IDX_DIP  = 254;

	// Game that offers the flip-screen hack
	localparam logic [BYTE_W-1:0] GAME_FLIP_HACK = 8'h02;
	// Trackball game, no DB15 pads
	localparam logic [BYTE_W-1:0] GAME_NO_SNAC   = 8'h14;

	// Menu mask after reset and for ordinary games
	localparam logic [MENU_W-1:0] MENU_RESET   = 16'h00FF;
	localparam logic [MENU_W-1:0] MENU_DEFAULT = 16'h00FD;

	// ======================================================================
	// Status bit positions
	// ======================================================================

	localparam int ST_RESET    = 0;
	// 2-bit aspect field starts here
	localparam int ST_AR_LO    = 8;
	localparam int ST_ORIENT   = 10;
	// Three layer-disable bits: side, back, front
	localparam int ST_LAYER_LO = 16;
	// Two SNAC bits, one per player
	localparam int ST_SNAC_LO  = 20;

endpackage

//--- logic/config_capture.sv
// Download-side configuration for the arcade core.
// Latches DIP bytes and the game byte from the download stream, gates
// ROM writes, builds the core reset and derives the game-dependent
// menu mask and DB15 enables.

`timescale 1ns/1ps

module config_capture (
	input  logic                                   clk_53p6,
	input  logic                                   rst_n,
	input  logic                                   ext_reset,
	input  logic [arcade_pkg::STATUS_W-1:0]        status,
	input  logic [1:0]                             osd_buttons,
	input  logic                                   ioctl_download,
	input  logic                                   ioctl_wr,
	input  logic [arcade_pkg::ADDR_W-1:0]          ioctl_addr,
	input  logic [arcade_pkg::BYTE_W-1:0]          ioctl_index,
	input  logic [arcade_pkg::BYTE_W-1:0]          ioctl_dout,
	output logic                                   core_reset,
	output logic                                   rom_wr,
	output logic [arcade_pkg::BYTE_W-1:0]          dsw1,
	output logic [arcade_pkg::BYTE_W-1:0]          dsw2,
	output logic [arcade_pkg::BYTE_W-1:0]          game,
	output logic [arcade_pkg::MENU_W-1:0]          status_menumask,
	output logic [1:0]                             snac_en
);

	logic                          dip_wr;
	logic                          game_wr;
	logic                          rom_sel;

	// ======================================================================
	// Download decode
	// ======================================================================

	// DIP write, address must land inside the slot range
	assign dip_wr = ioctl_wr
		&& (ioctl_index == arcade_pkg::BYTE_W'(arcade_pkg::IDX_DIP))
		&& (ioctl_addr < arcade_pkg::ADDR_W'(arcade_pkg::NUM_DIP));

	// Game byte lives at address 0 of its index
	assign game_wr = ioctl_wr
		&& (ioctl_index == arcade_pkg::BYTE_W'(arcade_pkg::IDX_GAME))
		&& (ioctl_addr == '0);

	assign rom_sel = ioctl_download
		&& (ioctl_index == arcade_pkg::BYTE_W'(arcade_pkg::IDX_ROM));

	// Only ROM data reaches the core's ROM ports
	assign rom_wr = ioctl_wr & rom_sel;

	// Any source holds the core in reset, including a running download
	assign core_reset = ext_reset | status[arcade_pkg::ST_RESET] | osd_buttons[1]
		| ioctl_download;

	// ======================================================================
	// Captured bytes
	// ======================================================================

	// Slots 0 and 1 are the core's DIP banks, other slots go nowhere
	always_ff @(posedge clk_53p6 or negedge rst_n) begin
		if (!rst_n) begin
			dsw1 <= '0;
			dsw2 <= '0;
		end else if (dip_wr) begin
			case (ioctl_addr[arcade_pkg::DIP_SEL_W-1:0])
				arcade_pkg::DIP_SEL_W'(0): dsw1 <= ioctl_dout;
				arcade_pkg::DIP_SEL_W'(1): dsw2 <= ioctl_dout;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_53p6 or negedge rst_n) begin
		if (!rst_n) begin
			game <= '0;
		end else if (game_wr) begin
			game <= ioctl_dout;
		end
	end

	// ======================================================================
	// Game-dependent settings
	// ======================================================================

	always_ff @(posedge clk_53p6 or negedge rst_n) begin
		if (!rst_n) begin
			status_menumask <= arcade_pkg::MENU_RESET;
		end else begin
			case (game)
				// Show the flip-screen hack
				arcade_pkg::GAME_FLIP_HACK: status_menumask[0] <= 1'b0;
				// Hide the DB15 page on the trackball game
				arcade_pkg::GAME_NO_SNAC:   status_menumask[1] <= 1'b1;
				default:                    status_menumask <= arcade_pkg::MENU_DEFAULT;
			endcase
		end
	end

	// DB15 pads unusable on the trackball game
	assign snac_en = (game == arcade_pkg::GAME_NO_SNAC) ? 2'b00
		: status[arcade_pkg::ST_SNAC_LO +: 2];

endmodule

//--- input/input_map.sv
// Controller mapping for one player.
// Picks the USB joystick or the DB15 pad, builds the active-low player
// word the core expects, flags pause and turns the analog stick into a
// trackball word. Purely combinational, one instance per player.

`timescale 1ns/1ps

module input_map (
	input  logic                               snac_en,
	input  logic [arcade_pkg::JOY_W-1:0]       usb_joy,
	input  logic [arcade_pkg::JOY_W-1:0]       db15_joy,
	input  logic [arcade_pkg::JOY_W-1:0]       analog,
	output logic [arcade_pkg::PLAYER_W-1:0]    player,
	output logic                               pause_req,
	output logic [arcade_pkg::JOY_W-1:0]       trackball
);

	// Active-high controls after the source choice
	logic up;
	logic down;
	logic left;
	logic right;
	logic btn1;
	logic btn2;
	logic start;
	logic coin;
	logic service;
	logic pause;

	// Trackball axes
	logic [arcade_pkg::TRACK_W-1:0] track_x;
	logic [arcade_pkg::TRACK_W-1:0] track_y;

	// ======================================================================
	// Source choice
	// ======================================================================

	always_comb begin
		if (snac_en) begin
			// DB15 pad, NeoGeo layout
			up      = db15_joy[3];
			down    = db15_joy[2];
			left    = db15_joy[1];
			right   = db15_joy[0];
			btn1    = db15_joy[5];
			btn2    = db15_joy[6];
			start   = db15_joy[10];
			coin    = db15_joy[11];
			// Select+B
			service = db15_joy[5] & db15_joy[11];
			// Select+A
			pause   = db15_joy[4] & db15_joy[11];
		end else begin
			// USB joystick, core button order
			up      = usb_joy[3];
			down    = usb_joy[2];
			left    = usb_joy[1];
			right   = usb_joy[0];
			btn1    = usb_joy[4];
			btn2    = usb_joy[5];
			start   = usb_joy[6];
			coin    = usb_joy[7];
			service = usb_joy[8];
			pause   = usb_joy[9];
		end
	end

	// ======================================================================
	// Outputs
	// ======================================================================

	// Unused core inputs sit high
	assign player = {2'b11, ~up, ~down, ~right, ~left, ~service,
		5'b11111, ~btn2, ~btn1, ~start, ~coin};

	assign pause_req = pause;

	// Y from the upper stick byte, X inverted from the lower byte
	assign track_y = analog[arcade_pkg::JOY_W-1 -: arcade_pkg::TRACK_W];
	assign track_x = ~analog[arcade_pkg::TRACK_W:1];

	assign trackball = {1'b0, track_y, 1'b0, track_x};

endmodule

//--- video/video_setup.sv
// Video settings from the OSD status word.
// Aspect ratio for the scaler and the registered layer enables
// for the core's debug layer switches.

`timescale 1ns/1ps

module video_setup (
	input  logic                               clk_53p6,
	input  logic                               rst_n,
	input  logic [arcade_pkg::STATUS_W-1:0]    status,
	output logic [12:0]                        video_arx,
	output logic [12:0]                        video_ary,
	output logic [2:0]                         layer_ena
);

	logic [1:0] ar;
	logic       horizontal;

	// ======================================================================
	// Aspect ratio
	// ======================================================================

	assign ar         = status[arcade_pkg::ST_AR_LO +: 2];
	// Bit clear means horizontal monitor
	assign horizontal = ~status[arcade_pkg::ST_ORIENT];

	always_comb begin
		if (ar == 2'd0) begin
			// Original ratio follows the monitor orientation
			if (horizontal) begin
				video_arx = 13'd4;
				video_ary = 13'd3;
			end else begin
				video_arx = 13'd3;
				video_ary = 13'd4;
			end
		end else begin
			// Full screen and the two custom ratios
			video_arx = {11'd0, ar - 2'd1};
			video_ary = 13'd0;
		end
	end

	// ======================================================================
	// Layer enables
	// ======================================================================

	// Side, back, front; status bits are disables
	always_ff @(posedge clk_53p6 or negedge rst_n) begin
		if (!rst_n) begin
			layer_ena <= 3'b111;
		end else begin
			layer_ena <= ~status[arcade_pkg::ST_LAYER_LO +: 3];
		end
	end

endmodule

//--- logic/audio_sync.sv
// Hands the two sound samples over to the audio clock.
// Two register stages per channel on clk_audio.

`timescale 1ns/1ps

module audio_sync (
	input  logic                               clk_audio,
	input  logic                               rst_n,
	input  logic [arcade_pkg::SAMPLE_W-1:0]    snd1,
	input  logic [arcade_pkg::SAMPLE_W-1:0]    snd2,
	output logic [arcade_pkg::SAMPLE_W-1:0]    audio_l,
	output logic [arcade_pkg::SAMPLE_W-1:0]    audio_r
);

	// First stage in the audio domain
	logic [arcade_pkg::SAMPLE_W-1:0] snd1_r;
	logic [arcade_pkg::SAMPLE_W-1:0] snd2_r;

	always_ff @(posedge clk_audio or negedge rst_n) begin
		if (!rst_n) begin
			snd1_r  <= '0;
			snd2_r  <= '0;
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			snd1_r  <= snd1;
			snd2_r  <= snd2;
			// Second stage feeds the DAC path
			audio_l <= snd1_r;
			audio_r <= snd2_r;
		end
	end

endmodule

//--- logic/arcade_glue_top.sv
// Board-side glue between the host I/O block and the game core.
// Ties download capture, both controller maps, video settings and
// the audio handover together.

`timescale 1ns/1ps

module arcade_glue_top (
	input  logic                               clk_53p6,
	input  logic                               clk_audio,
	input  logic                               rst_n,
	input  logic                               ext_reset,
	input  logic [arcade_pkg::STATUS_W-1:0]    status,
	input  logic [1:0]                         osd_buttons,
	input  logic                               ioctl_download,
	input  logic                               ioctl_wr,
	input  logic [arcade_pkg::ADDR_W-1:0]      ioctl_addr,
	input  logic [arcade_pkg::BYTE_W-1:0]      ioctl_index,
	input  logic [arcade_pkg::BYTE_W-1:0]      ioctl_dout,
	input  logic [arcade_pkg::JOY_W-1:0]       joystick_0,
	input  logic [arcade_pkg::JOY_W-1:0]       joystick_1,
	input  logic [arcade_pkg::JOY_W-1:0]       joy_db15_1,
	input  logic [arcade_pkg::JOY_W-1:0]       joy_db15_2,
	input  logic [arcade_pkg::JOY_W-1:0]       analog_l,
	input  logic [arcade_pkg::JOY_W-1:0]       analog_r,
	input  logic [arcade_pkg::SAMPLE_W-1:0]    snd1,
	input  logic [arcade_pkg::SAMPLE_W-1:0]    snd2,
	output logic                               core_reset,
	output logic                               rom_wr,
	output logic [arcade_pkg::BYTE_W-1:0]      dsw1,
	output logic [arcade_pkg::BYTE_W-1:0]      dsw2,
	output logic [arcade_pkg::BYTE_W-1:0]      game,
	output logic [arcade_pkg::MENU_W-1:0]      status_menumask,
	output logic [arcade_pkg::PLAYER_W-1:0]    player1,
	output logic [arcade_pkg::PLAYER_W-1:0]    player2,
	output logic                               pause_req,
	output logic [arcade_pkg::JOY_W-1:0]       trackball1,
	output logic [arcade_pkg::JOY_W-1:0]       trackball2,
	output logic [12:0]                        video_arx,
	output logic [12:0]                        video_ary,
	output logic [2:0]                         layer_ena,
	output logic [arcade_pkg::SAMPLE_W-1:0]    audio_l,
	output logic [arcade_pkg::SAMPLE_W-1:0]    audio_r
);

	// DB15 enable per player
	logic [1:0] snac_en;
	logic       pause_p1;
	logic       pause_p2;

	// ======================================================================
	// Download capture and game settings
	// ======================================================================

	config_capture u_config (
		.clk_53p6        (clk_53p6),
		.rst_n           (rst_n),
		.ext_reset       (ext_reset),
		.status          (status),
		.osd_buttons     (osd_buttons),
		.ioctl_download  (ioctl_download),
		.ioctl_wr        (ioctl_wr),
		.ioctl_addr      (ioctl_addr),
		.ioctl_index     (ioctl_index),
		.ioctl_dout      (ioctl_dout),
		.core_reset      (core_reset),
		.rom_wr          (rom_wr),
		.dsw1            (dsw1),
		.dsw2            (dsw2),
		.game            (game),
		.status_menumask (status_menumask),
		.snac_en         (snac_en)
	);

	// ======================================================================
	// Controllers
	// ======================================================================

	// Left stick drives player 1's trackball
	input_map map_p1 (
		.snac_en   (snac_en[0]),
		.usb_joy   (joystick_0),
		.db15_joy  (joy_db15_1),
		.analog    (analog_l),
		.player    (player1),
		.pause_req (pause_p1),
		.trackball (trackball1)
	);

	input_map map_p2 (
		.snac_en   (snac_en[1]),
		.usb_joy   (joystick_1),
		.db15_joy  (joy_db15_2),
		.analog    (analog_r),
		.player    (player2),
		.pause_req (pause_p2),
		.trackball (trackball2)
	);

	// Either player may pause
	assign pause_req = pause_p1 | pause_p2;

	// ======================================================================
	// Video and audio
	// ======================================================================

	video_setup u_video (
		.clk_53p6  (clk_53p6),
		.rst_n     (rst_n),
		.status    (status),
		.video_arx (video_arx),
		.video_ary (video_ary),
		.layer_ena (layer_ena)
	);

	audio_sync u_audio (
		.clk_audio (clk_audio),
		.rst_n     (rst_n),
		.snd1      (snd1),
		.snd2      (snd2),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

endmodule

//--- sim/tb_arcade_glue.sv
// Directed testbench for the arcade board glue.
// Drives the top level on the falling clock edge and checks against a
// model built from the bit maps and rules of each block.
// One line per test, then a summary and the verdict.

`timescale 1ns/1ps

module tb_arcade_glue;

	localparam int NUM_TESTS   = 7;
	localparam int WATCHDOG_NS = NUM_TESTS * 2000;

	logic                                clk_53p6;
	logic                                clk_audio;
	logic                                rst_n;
	logic                                ext_reset;
	logic [arcade_pkg::STATUS_W-1:0]     status;
	logic [1:0]                          osd_buttons;
	logic                                ioctl_download;
	logic                                ioctl_wr;
	logic [arcade_pkg::ADDR_W-1:0]       ioctl_addr;
	logic [arcade_pkg::BYTE_W-1:0]       ioctl_index;
	logic [arcade_pkg::BYTE_W-1:0]       ioctl_dout;
	logic [arcade_pkg::JOY_W-1:0]        joystick_0;
	logic [arcade_pkg::JOY_W-1:0]        joystick_1;
	logic [arcade_pkg::JOY_W-1:0]        joy_db15_1;
	logic [arcade_pkg::JOY_W-1:0]        joy_db15_2;
	logic [arcade_pkg::JOY_W-1:0]        analog_l;
	logic [arcade_pkg::JOY_W-1:0]        analog_r;
	logic [arcade_pkg::SAMPLE_W-1:0]     snd1;
	logic [arcade_pkg::SAMPLE_W-1:0]     snd2;
	logic                                core_reset;
	logic                                rom_wr;
	logic [arcade_pkg::BYTE_W-1:0]       dsw1;
	logic [arcade_pkg::BYTE_W-1:0]       dsw2;
	logic [arcade_pkg::BYTE_W-1:0]       game;
	logic [arcade_pkg::MENU_W-1:0]       status_menumask;
	logic [arcade_pkg::PLAYER_W-1:0]     player1;
	logic [arcade_pkg::PLAYER_W-1:0]     player2;
	logic                                pause_req;
	logic [arcade_pkg::JOY_W-1:0]        trackball1;
	logic [arcade_pkg::JOY_W-1:0]        trackball2;
	logic [12:0]                         video_arx;
	logic [12:0]                         video_ary;
	logic [2:0]                          layer_ena;
	logic [arcade_pkg::SAMPLE_W-1:0]     audio_l;
	logic [arcade_pkg::SAMPLE_W-1:0]     audio_r;

	integer seed         = 7202;
	int     errors       = 0;
	int     checks       = 0;
	int     tests_run    = 0;
	int     tests_failed = 0;

	arcade_glue_top dut0 (.*);

	// ======================================================================
	// Clocks and watchdog
	// ======================================================================

	initial begin
		clk_53p6 = 1'b0;
		forever #2 clk_53p6 = ~clk_53p6;
	end

	// Audio clock, unrelated to the system clock
	initial begin
		clk_audio = 1'b0;
		forever #20.5 clk_audio = ~clk_audio;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	// Active-low player word from the chosen source
	function automatic logic [15:0] player_word(input logic snac, input logic [15:0] usb,
		input logic [15:0] db15);
		logic [15:0] w;
		logic [15:0] src;
		src   = snac ? db15 : usb;
		w     = 16'hFFFF;
		// Directions share one layout on both sources
		w[13] = ~src[3];
		w[12] = ~src[2];
		w[11] = ~src[0];
		w[10] = ~src[1];
		w[9]  = snac ? ~(db15[5] & db15[11]) : ~usb[8];
		w[3]  = snac ? ~db15[6] : ~usb[5];
		w[2]  = snac ? ~db15[5] : ~usb[4];
		w[1]  = snac ? ~db15[10] : ~usb[6];
		w[0]  = snac ? ~db15[11] : ~usb[7];
		return w;
	endfunction

	function automatic logic pause_flag(input logic snac, input logic [15:0] usb,
		input logic [15:0] db15);
		return snac ? (db15[4] & db15[11]) : usb[9];
	endfunction

	// Y from the top seven bits, X inverted from bits 7 to 1
	function automatic logic [15:0] trackball_word(input logic [15:0] a);
		logic [15:0] w;
		w       = '0;
		w[14:8] = a[15:9];
		w[6:0]  = ~a[7:1];
		return w;
	endfunction

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors > errs_before) begin
			tests_failed++;
			$display("%-20s FAILED (%0d mismatches)", name, errors - errs_before);
		end else begin
			$display("%-20s ok", name);
		end
	endtask

	// One download byte, strobe high for a single clock
	task automatic write_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(negedge clk_53p6);
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		ioctl_wr    = 1'b1;
		@(negedge clk_53p6);
		ioctl_wr    = 1'b0;
	endtask

	// Random pads on both players with the given source
	task automatic pad_sweep(input logic snac);
		for (int i = 0; i < 16; i++) begin
			@(negedge clk_53p6);
			status = '0;
			status[arcade_pkg::ST_SNAC_LO +: 2] = {snac, snac};
			joystick_0 = 16'($random(seed));
			joystick_1 = 16'($random(seed));
			joy_db15_1 = 16'($random(seed));
			joy_db15_2 = 16'($random(seed));
			// Select with A or B for pause and service
			if (snac && (i % 3 == 1)) begin
				joy_db15_1 = joy_db15_1 | 16'h0810;
				joy_db15_2 = joy_db15_2 | 16'h0820;
			end else if (snac && (i % 3 == 2)) begin
				joy_db15_1 = joy_db15_1 | 16'h0820;
				joy_db15_2 = joy_db15_2 | 16'h0810;
			end
			#1;
			compare_value("player1", 32'(player1),
				32'(player_word(snac, joystick_0, joy_db15_1)));
			compare_value("player2", 32'(player2),
				32'(player_word(snac, joystick_1, joy_db15_2)));
			compare_value("pause_req", 32'(pause_req),
				32'(pause_flag(snac, joystick_0, joy_db15_1)
				| pause_flag(snac, joystick_1, joy_db15_2)));
		end
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic reset_values();
		int errs_before;
		errs_before = errors;
		// Assert on a falling edge, hold for three rising edges
		@(negedge clk_53p6);
		rst_n = 1'b0;
		repeat (3) @(negedge clk_53p6);
		compare_value("dsw1", 32'(dsw1), 32'h0);
		compare_value("dsw2", 32'(dsw2), 32'h0);
		compare_value("game", 32'(game), 32'h0);
		compare_value("status_menumask", 32'(status_menumask), 32'(arcade_pkg::MENU_RESET));
		compare_value("layer_ena", 32'(layer_ena), 32'h7);
		compare_value("audio_l", 32'(audio_l), 32'h0);
		compare_value("audio_r", 32'(audio_r), 32'h0);
		compare_value("rom_wr", 32'(rom_wr), 32'h0);
		rst_n = 1'b1;
		report_test("reset_values", errs_before);
	endtask

	task automatic dip_and_rom();
		logic [7:0] dip_bytes [arcade_pkg::NUM_DIP];
		int         errs_before;
		errs_before = errors;
		for (int i = 0; i < arcade_pkg::NUM_DIP; i++) begin
			dip_bytes[i] = 8'($random(seed));
			write_byte(8'(arcade_pkg::IDX_DIP), 25'(i), dip_bytes[i]);
		end
		compare_value("dsw1", 32'(dsw1), 32'(dip_bytes[0]));
		compare_value("dsw2", 32'(dsw2), 32'(dip_bytes[1]));
		// Wrong index, then an address past the last slot
		write_byte(8'h05, 25'd0, ~dip_bytes[0]);
		write_byte(8'(arcade_pkg::IDX_DIP), 25'(arcade_pkg::NUM_DIP), ~dip_bytes[0]);
		compare_value("dsw1", 32'(dsw1), 32'(dip_bytes[0]));
		compare_value("dsw2", 32'(dsw2), 32'(dip_bytes[1]));
		// Strobe, download and index in every combination
		for (int k = 0; k < 8; k++) begin
			@(negedge clk_53p6);
			ioctl_download = k[0];
			ioctl_wr       = k[1];
			ioctl_index    = k[2] ? 8'h03 : 8'(arcade_pkg::IDX_ROM);
			#1;
			compare_value("rom_wr", 32'(rom_wr), 32'(k[0] & k[1] & ~k[2]));
		end
		// Four reset sources, then osd button 0 and nothing
		for (int k = 0; k < 6; k++) begin
			@(negedge clk_53p6);
			ioctl_wr       = 1'b0;
			ext_reset      = (k == 0);
			status         = '0;
			status[arcade_pkg::ST_RESET] = (k == 1);
			osd_buttons    = (k == 2) ? 2'b10 : ((k == 4) ? 2'b01 : 2'b00);
			ioctl_download = (k == 3);
			#1;
			compare_value("core_reset", 32'(core_reset), 32'(k < 4));
		end
		report_test("dip_and_rom", errs_before);
	endtask

	task automatic game_select();
		logic [7:0]  codes [3];
		logic [15:0] mask_exp;
		logic [1:0]  snac_bits;
		logic [1:0]  snac_exp;
		int          errs_before;
		errs_before = errors;
		codes[0] = arcade_pkg::GAME_FLIP_HACK;
		codes[1] = arcade_pkg::GAME_NO_SNAC;
		do begin
			codes[2] = 8'($random(seed));
		end while (codes[2] == codes[0] || codes[2] == codes[1]);
		// Game 0 since reset counts as an ordinary game
		mask_exp = arcade_pkg::MENU_DEFAULT;
		compare_value("status_menumask", 32'(status_menumask), 32'(mask_exp));
		for (int i = 0; i < 3; i++) begin
			write_byte(8'(arcade_pkg::IDX_GAME), 25'd0, codes[i]);
			repeat (2) @(negedge clk_53p6);
			if (codes[i] == arcade_pkg::GAME_FLIP_HACK) begin
				mask_exp[0] = 1'b0;
			end else if (codes[i] == arcade_pkg::GAME_NO_SNAC) begin
				mask_exp[1] = 1'b1;
			end else begin
				mask_exp = arcade_pkg::MENU_DEFAULT;
			end
			// Different SNAC bits per game, only the DB15 pads press anything
			snac_bits = 2'(i + 1);
			status[arcade_pkg::ST_SNAC_LO +: 2] = snac_bits;
			joystick_0 = '0;
			joystick_1 = '0;
			joy_db15_1 = 16'h0001;
			joy_db15_2 = 16'h0008;
			#1;
			// Trackball game ignores both SNAC bits
			snac_exp = (codes[i] == arcade_pkg::GAME_NO_SNAC) ? 2'b00 : snac_bits;
			compare_value("game", 32'(game), 32'(codes[i]));
			compare_value("status_menumask", 32'(status_menumask), 32'(mask_exp));
			compare_value("player1", 32'(player1),
				32'(player_word(snac_exp[0], joystick_0, joy_db15_1)));
			compare_value("player2", 32'(player2),
				32'(player_word(snac_exp[1], joystick_1, joy_db15_2)));
		end
		report_test("game_select", errs_before);
	endtask

	task automatic usb_mapping();
		int errs_before;
		errs_before = errors;
		pad_sweep(1'b0);
		report_test("usb_mapping", errs_before);
	endtask

	task automatic db15_mapping();
		int errs_before;
		errs_before = errors;
		pad_sweep(1'b1);
		report_test("db15_mapping", errs_before);
	endtask

	task automatic video_and_trackball();
		logic [12:0] arx_exp;
		logic [12:0] ary_exp;
		logic [2:0]  disable_bits;
		logic [2:0]  ena_exp;
		logic [2:0]  ena_prev;
		int          errs_before;
		errs_before = errors;
		for (int ar = 0; ar < 4; ar++) begin
			for (int ori = 0; ori < 2; ori++) begin
				@(negedge clk_53p6);
				status = '0;
				status[arcade_pkg::ST_AR_LO +: 2] = 2'(ar);
				status[arcade_pkg::ST_ORIENT]     = (ori == 1);
				if (ar == 0) begin
					arx_exp = (ori == 1) ? 13'd3 : 13'd4;
					ary_exp = (ori == 1) ? 13'd4 : 13'd3;
				end else begin
					arx_exp = 13'(ar - 1);
					ary_exp = '0;
				end
				#1;
				compare_value("video_arx", 32'(video_arx), 32'(arx_exp));
				compare_value("video_ary", 32'(video_ary), 32'(ary_exp));
			end
		end
		// Layer enables one clock behind, all on while no disable is set
		ena_prev = 3'b111;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_53p6);
			disable_bits = 3'($random(seed));
			status[arcade_pkg::ST_LAYER_LO +: 3] = disable_bits;
			ena_exp = ~disable_bits;
			#1;
			compare_value("layer_ena", 32'(layer_ena), 32'(ena_prev));
			@(negedge clk_53p6);
			compare_value("layer_ena", 32'(layer_ena), 32'(ena_exp));
			ena_prev = ena_exp;
		end
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_53p6);
			analog_l = 16'($random(seed));
			analog_r = 16'($random(seed));
			#1;
			compare_value("trackball1", 32'(trackball1), 32'(trackball_word(analog_l)));
			compare_value("trackball2", 32'(trackball2), 32'(trackball_word(analog_r)));
		end
		report_test("video_and_trackball", errs_before);
	endtask

	task automatic audio_handover();
		logic [15:0] prev_l;
		logic [15:0] prev_r;
		int          errs_before;
		errs_before = errors;
		// Samples held at zero since reset
		prev_l = '0;
		prev_r = '0;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk_53p6);
			snd1 = 16'($random(seed));
			snd2 = 16'($random(seed));
			// One edge in, the new sample sits in the first stage only
			@(posedge clk_audio);
			@(negedge clk_audio);
			compare_value("audio_l", 32'(audio_l), 32'(prev_l));
			compare_value("audio_r", 32'(audio_r), 32'(prev_r));
			repeat (2) @(posedge clk_audio);
			// Sample away from the audio edge
			@(negedge clk_audio);
			compare_value("audio_l", 32'(audio_l), 32'(snd1));
			compare_value("audio_r", 32'(audio_r), 32'(snd2));
			prev_l = snd1;
			prev_r = snd2;
		end
		report_test("audio_handover", errs_before);
	endtask

	// ======================================================================
	// Sequence
	// ======================================================================

	initial begin
		rst_n          = 1'b1;
		ext_reset      = 1'b0;
		status         = '0;
		osd_buttons    = '0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_index    = '0;
		ioctl_dout     = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		joy_db15_1     = '0;
		joy_db15_2     = '0;
		analog_l       = '0;
		analog_r       = '0;
		snd1           = '0;
		snd2           = '0;

		reset_values();
		dip_and_rom();
		game_select();
		usb_mapping();
		db15_mapping();
		video_and_trackball();
		audio_handover();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- list.f
common/arcade_pkg.sv
logic/config_capture.sv
input/input_map.sv
video/video_setup.sv
logic/audio_sync.sv
logic/arcade_glue_top.sv
sim/tb_arcade_glue.sv

//--- Makefile
# Verilator flow for the arcade board glue
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_arcade_glue
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
